/* seg_int_cfg.svh */
////////////////////////////////////////////////////////////
// Widths and segment count for the segment interrupt
// controller. Include it in every file that sizes a port,
// a struct field or an array from these values.
////////////////////////////////////////////////////////////
`ifndef SEG_INT_CFG_SVH
`define SEG_INT_CFG_SVH

// Sticky word, also the interrupt enable word
`define SEG_INT_STYW   5

// Status word
`define SEG_INT_STAW   5

// Low status bits that can raise a sticky on change
`define SEG_INT_CHGW   5

// Segment id width
`define SEG_INT_SEGB   4

// Segments in use, at most 2**SEG_INT_SEGB
`define SEG_INT_SEGNUM 12

// Processor data bus, wide enough for the pending vector
`define SEG_INT_UPW    12

`endif

/* seg_int_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the segment interrupt controller: the
// status event, the channel buffer word and the processor
// request. Modules refer to them as seg_int_pkg::name.
////////////////////////////////////////////////////////////
`include "seg_int_cfg.svh"

package seg_int_pkg;

  // Processor register select
  localparam logic [1:0] REG_STICKY = 2'd0; // Write one to clear
  localparam logic [1:0] REG_STA    = 2'd1;
  localparam logic [1:0] REG_INTEN  = 2'd2;
  localparam logic [1:0] REG_PEND   = 2'd3; // Read only, one bit per segment

  // One status event for one segment
  typedef struct packed {
    logic [`SEG_INT_SEGB-1:0] seg;         // Target segment
    logic [`SEG_INT_STYW-1:0] sty_req;     // Stickies to set directly
    logic [`SEG_INT_STAW-1:0] sta;         // New status value
    logic [`SEG_INT_STAW-1:0] sta_msk;     // Status bits to write
    logic [`SEG_INT_CHGW-1:0] sta_chg_en;  // Bit i watches sta[i] for change
    logic [`SEG_INT_STYW-1:0] int_type_en; // Per type gate into pending
  } seg_evt_t;

  ////////////////////////////////////////////////////////////
  // Channel buffer word, interrupt enable in the top bits
  typedef struct packed {
    logic [`SEG_INT_STYW-1:0] inten;
    logic [`SEG_INT_STAW-1:0] sta;
    logic [`SEG_INT_STYW-1:0] sticky;
  } ch_word_t;

  // One processor access
  typedef struct packed {
    logic                     wr;      // 1 write, 0 read
    logic [`SEG_INT_SEGB-1:0] seg;
    logic [1:0]               reg_sel; // See REG_* above
    logic [`SEG_INT_UPW-1:0]  wdata;
  } up_req_t;

endpackage

/* seg_ch_ram.sv */
////////////////////////////////////////////////////////////
// Channel buffer, one word per segment. One write port and
// one read port, read data registered and held between
// reads. Contents start unknown until written.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "seg_int_cfg.svh"

module seg_ch_ram (
  input  logic                      iclk,
  input  logic                      wr_en,
  input  logic [`SEG_INT_SEGB-1:0]  wr_seg,
  input  seg_int_pkg::ch_word_t     wr_data,
  input  logic                      rd_en,
  input  logic [`SEG_INT_SEGB-1:0]  rd_seg,
  output seg_int_pkg::ch_word_t     rd_data
);

  localparam int SEGN = `SEG_INT_SEGNUM;

  seg_int_pkg::ch_word_t mem [SEGN]; // Sticky, status, inten per segment

  // Write port
  always_ff @(posedge iclk)
  begin
    if (wr_en)
      mem[wr_seg] <= wr_data;
  end

  ////////////////////////////////////////////////////////////
  // Read port, old data on a same cycle write
  always_ff @(posedge iclk)
  begin
    if (rd_en)
      rd_data <= mem[rd_seg];
  end

endmodule

/* seg_alarm_reraise.sv */
////////////////////////////////////////////////////////////
// Alarm re-raise sequencer in front of the interrupt engine.
// A rising edge on alarm_rest walks all segments, clears and
// restores each status so active alarms set their stickies
// again. External events pass through when idle.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "seg_int_cfg.svh"

module seg_alarm_reraise (
  input  logic                   iclk,
  input  logic                   arst_n,
  input  logic                   alarm_rest,
  input  logic                   evt_valid,
  input  seg_int_pkg::seg_evt_t  evt,
  input  seg_int_pkg::ch_word_t  rd_data,
  output logic                   eng_valid,
  output seg_int_pkg::seg_evt_t  eng_evt
);

  localparam int SEGB = `SEG_INT_SEGB;
  localparam int STAW = `SEG_INT_STAW;
  localparam logic [SEGB-1:0] LAST_SEG = SEGB'(`SEG_INT_SEGNUM - 1);

  typedef enum logic [2:0] {
    IDLE,     // Pass external events
    PREREAD,  // Read current status
    WAIT1,
    WAIT2,    // Read data on its way
    CLEARSTA, // Write status zero, latch old status
    SETSTK    // Write old status back
  } walk_state_t;

  logic [2:0]            sync_q;  // Synchronizer and edge history
  logic                  rise;
  walk_state_t           state;
  logic [SEGB-1:0]       seg_cnt;
  logic [STAW-1:0]       sta_lat; // Status before the clear
  seg_int_pkg::seg_evt_t own_evt;
  logic                  own_valid;

  assign rise = sync_q[1] & ~sync_q[2];

  ////////////////////////////////////////////////////////////
  // Own events of the walk
  always_comb
  begin
    own_evt             = '0;   // No sticky request
    own_evt.seg         = seg_cnt;
    own_evt.sta_chg_en  = '1;   // Watch every change bit
    own_evt.int_type_en = '1;
    case (state)
      CLEARSTA: own_evt.sta_msk = '1;
      SETSTK:
      begin
        own_evt.sta_msk = '1;
        own_evt.sta     = sta_lat;
      end
      default:  own_evt.sta_msk = '0; // Plain read, status untouched
    endcase
  end

  assign own_valid = (state == PREREAD) || (state == CLEARSTA) || (state == SETSTK);

  ////////////////////////////////////////////////////////////
  // Walk FSM
  always_ff @(posedge iclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_q    <= '0;
      state     <= IDLE;
      seg_cnt   <= '0;
      eng_valid <= 1'b0;
    end
    else
    begin
      sync_q <= {sync_q[1:0], alarm_rest};
      // External events only reach the engine while idle
      eng_valid <= (state == IDLE) ? evt_valid : own_valid;
      case (state)
        IDLE:
        begin
          seg_cnt <= '0;
          if (rise)
            state <= PREREAD;
        end
        PREREAD:  state <= WAIT1;
        WAIT1:    state <= WAIT2;
        WAIT2:    state <= CLEARSTA;
        CLEARSTA: state <= SETSTK;
        SETSTK:
        begin
          seg_cnt <= seg_cnt + 1'b1;
          state   <= (seg_cnt == LAST_SEG) ? IDLE : PREREAD; // Last segment done
        end
        default:  state <= IDLE;
      endcase
    end
  end

  // Event payload and latched status
  always_ff @(posedge iclk)
  begin
    eng_evt <= (state == IDLE) ? evt : own_evt;
    if (state == CLEARSTA)
      sta_lat <= rd_data.sta; // Read data of PREREAD is valid here
  end

endmodule

/* seg_int_engine.sv */
////////////////////////////////////////////////////////////
// Read-modify-write engine of the segment interrupt
// controller. Stage one issues the buffer read, stage two
// merges and writes, stage three forwards the write and
// updates pending. Processor accesses use free slots.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "seg_int_cfg.svh"

module seg_int_engine (
  input  logic                      iclk,
  input  logic                      arst_n,
  input  logic                      eng_valid,
  input  seg_int_pkg::seg_evt_t     eng_evt,
  input  logic                      up_stb,
  input  seg_int_pkg::up_req_t      up,
  input  seg_int_pkg::ch_word_t     rd_data,
  output logic                      rd_en,
  output logic [`SEG_INT_SEGB-1:0]  rd_seg,
  output logic                      wr_en,
  output logic [`SEG_INT_SEGB-1:0]  wr_seg,
  output seg_int_pkg::ch_word_t     wr_data,
  output logic                      up_rdy,
  output logic [`SEG_INT_UPW-1:0]   up_rdata,
  output logic                      irq
);

  localparam int STYW = `SEG_INT_STYW;
  localparam int STAW = `SEG_INT_STAW;
  localparam int CHGW = `SEG_INT_CHGW;
  localparam int SEGB = `SEG_INT_SEGB;
  localparam int SEGN = `SEG_INT_SEGNUM;
  localparam int UPW  = `SEG_INT_UPW;

  // Processor request holding register
  logic                  up_pend;
  seg_int_pkg::up_req_t  up_q;
  logic                  up_take;   // Slot free, request enters stage one

  // Pipeline stages
  logic                  s1_valid, s1_up;
  seg_int_pkg::seg_evt_t s1_evt;
  seg_int_pkg::up_req_t  s1_upr;
  logic                  s2_valid, s2_up;
  seg_int_pkg::seg_evt_t s2_evt;
  seg_int_pkg::up_req_t  s2_upr;
  logic [SEGB-1:0]       s2_seg;
  logic                  s3_wr;
  logic [SEGB-1:0]       s3_seg;
  seg_int_pkg::ch_word_t s3_data;
  logic [STYW-1:0]       s3_ten;

  // Modify step
  logic                  fwd_hit;
  seg_int_pkg::ch_word_t old_word;
  logic [STYW-1:0]       old_ten;
  logic [STAW-1:0]       sta_mrg;
  logic [CHGW-1:0]       chg_bits;
  seg_int_pkg::ch_word_t new_word;
  logic [STYW-1:0]       new_ten;
  logic [UPW-1:0]        rdata_nx;

  logic [SEGN-1:0]       pending;
  logic [STYW-1:0]       type_en [SEGN]; // Last type enable seen per segment

  assign up_take = up_pend & ~eng_valid; // Events always win

  ////////////////////////////////////////////////////////////
  // Stage one, buffer read
  assign rd_en  = s1_valid;
  assign rd_seg = s1_up ? s1_upr.seg : s1_evt.seg;

  ////////////////////////////////////////////////////////////
  // Stage two, merge and write
  assign s2_seg  = s2_up ? s2_upr.seg : s2_evt.seg;
  assign fwd_hit = s3_wr && (s3_seg == s2_seg); // Buffer read missed last write
  assign old_word = fwd_hit ? s3_data : rd_data;
  assign old_ten  = fwd_hit ? s3_ten : type_en[s2_seg];

  assign sta_mrg  = (old_word.sta & ~s2_evt.sta_msk) | (s2_evt.sta & s2_evt.sta_msk);
  assign chg_bits = (old_word.sta[CHGW-1:0] ^ sta_mrg[CHGW-1:0]) & s2_evt.sta_chg_en;

  always_comb
  begin
    new_word = old_word;
    new_ten  = old_ten;
    wr_en    = 1'b0;
    rdata_nx = '0;
    if (s2_up)
    begin
      case (s2_upr.reg_sel)
        seg_int_pkg::REG_STICKY:
        begin
          rdata_nx        = UPW'(old_word.sticky);
          new_word.sticky = old_word.sticky & ~s2_upr.wdata[STYW-1:0]; // W1C
        end
        seg_int_pkg::REG_STA:
        begin
          rdata_nx     = UPW'(old_word.sta);
          new_word.sta = s2_upr.wdata[STAW-1:0];
        end
        seg_int_pkg::REG_INTEN:
        begin
          rdata_nx       = UPW'(old_word.inten);
          new_word.inten = s2_upr.wdata[STYW-1:0];
        end
        default: rdata_nx = UPW'(pending); // Read only
      endcase
      wr_en = s2_valid && s2_upr.wr && (s2_upr.reg_sel != seg_int_pkg::REG_PEND);
    end
    else
    begin
      new_word.sta    = sta_mrg;
      new_word.sticky = old_word.sticky | s2_evt.sty_req | STYW'(chg_bits);
      new_ten         = s2_evt.int_type_en;
      wr_en           = s2_valid;
    end
  end

  assign wr_seg  = s2_seg;
  assign wr_data = new_word;

  assign irq = |pending;

  ////////////////////////////////////////////////////////////
  // Control state
  always_ff @(posedge iclk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_pend  <= 1'b0;
      s1_valid <= 1'b0;
      s1_up    <= 1'b0;
      s2_valid <= 1'b0;
      s2_up    <= 1'b0;
      s3_wr    <= 1'b0;
      up_rdy   <= 1'b0;
      pending  <= '0;
      for (int i = 0; i < SEGN; i++)
        type_en[i] <= '1;
    end
    else
    begin
      if (up_take)
        up_pend <= 1'b0;
      if (up_stb)
        up_pend <= 1'b1;
      s1_valid <= eng_valid | up_take;
      s1_up    <= up_take;
      s2_valid <= s1_valid;
      s2_up    <= s1_up;
      s3_wr    <= wr_en;
      up_rdy   <= s2_valid & s2_up; // Two cycles after entry
      if (s3_wr)
      begin
        pending[s3_seg] <= |(s3_data.sticky & s3_data.inten & s3_ten);
        type_en[s3_seg] <= s3_ten;
      end
    end
  end

  // Payload registers
  always_ff @(posedge iclk)
  begin
    if (up_stb)
      up_q <= up;
    s1_evt   <= eng_evt;
    s1_upr   <= up_q;
    s2_evt   <= s1_evt;
    s2_upr   <= s1_upr;
    s3_seg   <= wr_seg;   // Also the forward copy
    s3_data  <= wr_data;
    s3_ten   <= new_ten;
    up_rdata <= rdata_nx;
  end

endmodule

/* seg_int_top.sv */
////////////////////////////////////////////////////////////
// Top level of the segment interrupt controller. Events go
// through the alarm re-raise sequencer into the engine,
// which keeps its per-segment words in the channel buffer.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "seg_int_cfg.svh"

module seg_int_top (
  input  logic                     iclk,
  input  logic                     arst_n,
  input  logic                     alarm_rest,
  input  logic                     evt_valid,
  input  seg_int_pkg::seg_evt_t    evt,
  input  logic                     up_stb,
  input  seg_int_pkg::up_req_t     up,
  output logic                     up_rdy,
  output logic [`SEG_INT_UPW-1:0]  up_rdata,
  output logic                     irq
);

  // Sequencer to engine
  logic                      eng_valid;
  seg_int_pkg::seg_evt_t     eng_evt;

  // Engine to channel buffer
  logic                      rd_en;
  logic [`SEG_INT_SEGB-1:0]  rd_seg;
  logic                      wr_en;
  logic [`SEG_INT_SEGB-1:0]  wr_seg;
  seg_int_pkg::ch_word_t     wr_data;
  seg_int_pkg::ch_word_t     rd_data;  // To engine and sequencer

  seg_alarm_reraise reraise0 (
    .iclk       (iclk),
    .arst_n     (arst_n),
    .alarm_rest (alarm_rest),
    .evt_valid  (evt_valid),
    .evt        (evt),
    .rd_data    (rd_data),
    .eng_valid  (eng_valid),
    .eng_evt    (eng_evt)
  );

  seg_int_engine engine0 (
    .iclk      (iclk),
    .arst_n    (arst_n),
    .eng_valid (eng_valid),
    .eng_evt   (eng_evt),
    .up_stb    (up_stb),
    .up        (up),
    .rd_data   (rd_data),
    .rd_en     (rd_en),
    .rd_seg    (rd_seg),
    .wr_en     (wr_en),
    .wr_seg    (wr_seg),
    .wr_data   (wr_data),
    .up_rdy    (up_rdy),
    .up_rdata  (up_rdata),
    .irq       (irq)
  );

  seg_ch_ram ram0 (
    .iclk    (iclk),
    .wr_en   (wr_en),
    .wr_seg  (wr_seg),
    .wr_data (wr_data),
    .rd_en   (rd_en),
    .rd_seg  (rd_seg),
    .rd_data (rd_data)
  );

endmodule

/* seg_int_properties.sv */
////////////////////////////////////////////////////////////
// Concurrent checks on the interrupt engine, bound into
// every seg_int_engine instance by the bind at the bottom.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "seg_int_cfg.svh"

module seg_int_properties (
  input logic                        iclk,
  input logic                        arst_n,
  input logic                        rd_en,
  input logic [`SEG_INT_SEGB-1:0]    rd_seg,
  input logic                        wr_en,
  input logic [`SEG_INT_SEGB-1:0]    wr_seg,
  input seg_int_pkg::ch_word_t       wr_data,
  input logic [`SEG_INT_STYW-1:0]    new_ten,
  input logic                        up_rdy,
  input logic                        irq
);

  int fail_cnt = 0; // Failed checks so far

  // Write goes to the segment whose buffer read was the cycle before
  wr_after_rd: assert property (@(posedge iclk) disable iff (!arst_n)
    wr_en |-> ($past(rd_en) && ($past(rd_seg) == wr_seg)))
    else
    begin
      $error("buffer write without a read of the same segment the cycle before");
      fail_cnt++;
    end

  // Enabled sticky in a written word shows on irq once pending updates
  irq_on_cause: assert property (@(posedge iclk) disable iff (!arst_n)
    (wr_en && |(wr_data.sticky & wr_data.inten & new_ten)) |-> ##2 irq)
    else
    begin
      $error("irq stays low after a write with an enabled sticky bit");
      fail_cnt++;
    end

  no_x_rdy: assert property (@(posedge iclk) !$isunknown(up_rdy))
    else
    begin
      $error("up_rdy is unknown");
      fail_cnt++;
    end

endmodule

bind seg_int_engine seg_int_properties props0 (
  .iclk    (iclk),
  .arst_n  (arst_n),
  .rd_en   (rd_en),
  .rd_seg  (rd_seg),
  .wr_en   (wr_en),
  .wr_seg  (wr_seg),
  .wr_data (wr_data),
  .new_ten (new_ten),
  .up_rdy  (up_rdy),
  .irq     (irq)
);

/* tb_seg_int.sv */
////////////////////////////////////////////////////////////
// Testbench of the segment interrupt controller. Random
// events and processor accesses run against a reference
// model, then an alarm re-raise walk is checked.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "seg_int_cfg.svh"

module tb_seg_int;

  localparam int SEGN     = `SEG_INT_SEGNUM;
  localparam int SEGB     = `SEG_INT_SEGB;
  localparam int STYW     = `SEG_INT_STYW;
  localparam int STAW     = `SEG_INT_STAW;
  localparam int CHGW     = `SEG_INT_CHGW;
  localparam int UPW      = `SEG_INT_UPW;
  localparam int PERIOD   = 40;
  localparam int ACC_CYC  = 12;           // Bound on one processor access
  localparam int SETTLE   = 8;            // Event pipeline drain
  localparam int WALK_CYC = 3 + 5 * SEGN; // Edge detect plus five states per segment
  localparam int N_BURST  = 20;
  localparam int RUN_CYC  = 16 * SEGN * ACC_CYC + 3 * N_BURST * (4 + SETTLE)
                            + 2 * WALK_CYC + 200;

  logic                  iclk;
  logic                  arst_n;
  logic                  alarm_rest;
  logic                  evt_valid;
  seg_int_pkg::seg_evt_t evt;
  logic                  up_stb;
  seg_int_pkg::up_req_t  up;
  logic                  up_rdy;
  logic [UPW-1:0]        up_rdata;
  logic                  irq;

  // Reference model, one entry per segment
  logic [STYW-1:0]       m_sty   [SEGN];
  logic [STAW-1:0]       m_sta   [SEGN];
  logic [STYW-1:0]       m_inten [SEGN];
  logic [STYW-1:0]       m_ten   [SEGN]; // Last type enable

  string                 tname;
  int                    t_chk, t_err, n_chk, n_err, n_test;
  logic [UPW-1:0]        rd;
  seg_int_pkg::seg_evt_t e;

  seg_int_top dut0 (
    .iclk       (iclk),
    .arst_n     (arst_n),
    .alarm_rest (alarm_rest),
    .evt_valid  (evt_valid),
    .evt        (evt),
    .up_stb     (up_stb),
    .up         (up),
    .up_rdy     (up_rdy),
    .up_rdata   (up_rdata),
    .irq        (irq)
  );

  initial
  begin
    iclk = 1'b0;
    forever #(PERIOD / 2) iclk = ~iclk;
  end

  ////////////////////////////////////////////////////////////
  // Model rules
  function automatic logic [SEGN-1:0] model_pend();
    logic [SEGN-1:0] p;
    for (int i = 0; i < SEGN; i++)
      p[i] = |(m_sty[i] & m_inten[i] & m_ten[i]);
    return p;
  endfunction

  function automatic void model_evt(seg_int_pkg::seg_evt_t ev);
    logic [STAW-1:0] mrg;
    logic [CHGW-1:0] chg;
    mrg = (m_sta[ev.seg] & ~ev.sta_msk) | (ev.sta & ev.sta_msk); // Masked write
    chg = (m_sta[ev.seg][CHGW-1:0] ^ mrg[CHGW-1:0]) & ev.sta_chg_en;
    m_sty[ev.seg] = m_sty[ev.seg] | ev.sty_req | STYW'(chg);
    m_sta[ev.seg] = mrg;
    m_ten[ev.seg] = ev.int_type_en;
  endfunction

  function automatic seg_int_pkg::seg_evt_t rand_evt(int seg);
    seg_int_pkg::seg_evt_t ev;
    ev.seg         = SEGB'(seg);
    ev.sty_req     = ($urandom_range(3) == 0) ? STYW'($urandom) : '0; // Mostly change driven
    ev.sta         = STAW'($urandom);
    ev.sta_msk     = STAW'($urandom);
    ev.sta_chg_en  = CHGW'($urandom);
    ev.int_type_en = STYW'($urandom);
    return ev;
  endfunction

  ////////////////////////////////////////////////////////////
  // Drivers and checks
  task automatic check_val(string what, logic [UPW-1:0] exp, logic [UPW-1:0] act);
    t_chk++;
    if (act !== exp)
    begin
      $display("** Error %s: %s expected %h actual %h", tname, what, exp, act);
      t_err++;
    end
  endtask

  task automatic up_access(logic wr, int seg, logic [1:0] sel, logic [UPW-1:0] wd,
                           output logic [UPW-1:0] rdata);
    seg_int_pkg::up_req_t req;
    int                   waited;
    req.wr      = wr;
    req.seg     = SEGB'(seg);
    req.reg_sel = sel;
    req.wdata   = wd;
    rdata       = '0;
    @(posedge iclk);
    up_stb <= 1'b1;
    up     <= req;
    @(posedge iclk);
    up_stb <= 1'b0;
    waited = 0;
    @(negedge iclk);
    while (!up_rdy && waited < ACC_CYC) // Latency varies behind events
    begin
      @(negedge iclk);
      waited++;
    end
    if (up_rdy)
      rdata = up_rdata;
    else
    begin
      $display("Error in %s: no ready pulse for the access to segment %0d", tname, seg);
      t_err++;
    end
  endtask

  task automatic up_write(int seg, logic [1:0] sel, logic [UPW-1:0] wd);
    logic [UPW-1:0] old_val;
    up_access(1'b1, seg, sel, wd, old_val);
    case (sel)
      seg_int_pkg::REG_STICKY: m_sty[seg] = m_sty[seg] & ~wd[STYW-1:0]; // W1C
      seg_int_pkg::REG_STA:    m_sta[seg] = wd[STAW-1:0];
      seg_int_pkg::REG_INTEN:  m_inten[seg] = wd[STYW-1:0];
      default: ;
    endcase
  endtask

  task automatic drive_evt(logic v, seg_int_pkg::seg_evt_t ev);
    @(posedge iclk);
    evt_valid <= v;
    evt       <= ev;
  endtask

  task automatic event_burst();
    seg_int_pkg::seg_evt_t ev;
    int                    seg;
    seg = $urandom_range(SEGN - 1);
    for (int i = 0; i < 1 + $urandom_range(3); i++)
    begin
      if (i > 0 && $urandom_range(1) == 1)
        seg = $urandom_range(SEGN - 1); // Else same segment back to back
      ev = rand_evt(seg);
      drive_evt(1'b1, ev);
      model_evt(ev);
    end
    drive_evt(1'b0, '0);
    repeat (SETTLE) @(posedge iclk);
  endtask

  task automatic check_irq();
    logic [UPW-1:0] rdv;
    @(negedge iclk);
    check_val("irq", UPW'(|model_pend()), UPW'(irq));
    up_access(1'b0, 0, seg_int_pkg::REG_PEND, '0, rdv);
    check_val("pending", UPW'(model_pend()), rdv);
  endtask

  task automatic read_back();
    logic [UPW-1:0] rdv;
    for (int i = 0; i < SEGN; i++)
    begin
      up_access(1'b0, i, seg_int_pkg::REG_STICKY, '0, rdv);
      check_val($sformatf("sticky %0d", i), UPW'(m_sty[i]), rdv);
      up_access(1'b0, i, seg_int_pkg::REG_STA, '0, rdv);
      check_val($sformatf("status %0d", i), UPW'(m_sta[i]), rdv);
    end
  endtask

  task automatic end_test();
    $display("test %-7s %0d checks, %0d errors", tname, t_chk, t_err);
    n_chk = n_chk + t_chk;
    n_err = n_err + t_err;
    n_test++;
    t_chk = 0;
    t_err = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  initial
  begin
    void'($urandom(82));
    arst_n     = 1'b0;
    alarm_rest = 1'b0;
    evt_valid  = 1'b0;
    evt        = '0;
    up_stb     = 1'b0;
    up         = '0;
    t_chk      = 0;
    t_err      = 0;
    n_chk      = 0;
    n_err      = 0;
    n_test     = 0;
    for (int i = 0; i < SEGN; i++)
      m_ten[i] = '1; // Engine resets all type enables high
    repeat (2) @(posedge iclk);
    arst_n <= 1'b1;

    tname = "inten";
    for (int i = 0; i < SEGN; i++)
    begin
      up_write(i, seg_int_pkg::REG_STICKY, '1);
      up_write(i, seg_int_pkg::REG_STA, '0);
      up_write(i, seg_int_pkg::REG_INTEN, '0);
      up_write(i, seg_int_pkg::REG_INTEN, UPW'($urandom));
      up_access(1'b0, i, seg_int_pkg::REG_INTEN, '0, rd);
      check_val($sformatf("inten %0d", i), UPW'(m_inten[i]), rd);
    end
    end_test();

    tname = "events";
    repeat (N_BURST) event_burst();
    read_back();
    end_test();

    tname = "irq";
    repeat (N_BURST)
    begin
      event_burst();
      check_irq();
    end
    for (int i = 0; i < SEGN; i += 3)
    begin
      up_write(i, seg_int_pkg::REG_STICKY, '1);
      check_irq();
    end
    end_test();

    tname = "w1c";
    for (int i = 0; i < SEGN; i++)
    begin
      e = rand_evt(i);
      e.sty_req = '1; // All stickies set before the clear
      drive_evt(1'b1, e);
      model_evt(e);
      drive_evt(1'b0, '0);
      repeat (SETTLE) @(posedge iclk);
      up_write(i, seg_int_pkg::REG_STICKY, UPW'($urandom));
      up_access(1'b0, i, seg_int_pkg::REG_STICKY, '0, rd);
      check_val($sformatf("sticky %0d", i), UPW'(m_sty[i]), rd);
    end
    end_test();

    tname = "walk";
    @(posedge iclk);
    alarm_rest <= 1'b1;
    repeat (5) @(posedge iclk); // Past the edge detector
    repeat (40)
      drive_evt(1'b1, rand_evt($urandom_range(SEGN - 1))); // Dropped during the walk
    drive_evt(1'b0, '0);
    repeat (WALK_CYC + SETTLE) @(posedge iclk);
    alarm_rest <= 1'b0;
    for (int i = 0; i < SEGN; i++)
    begin
      m_sty[i] = m_sty[i] | STYW'(m_sta[i][CHGW-1:0]); // Active alarms raised again
      m_ten[i] = '1;
    end
    read_back();
    check_irq();
    end_test();

    n_err = n_err + dut0.engine0.props0.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", n_test, n_chk, n_err);
    if (n_err == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(RUN_CYC * PERIOD);
    $display("Error: the run did not finish within %0d cycles", RUN_CYC);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* all.f */
+incdir+.
seg_int_pkg.sv
seg_ch_ram.sv
seg_alarm_reraise.sv
seg_int_engine.sv
seg_int_top.sv
seg_int_properties.sv
tb_seg_int.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_seg_int \
  -f all.f -o sim_seg_int
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let assertion errors be counted instead of stopping at the first one
out=$(./obj_dir/sim_seg_int +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1
